//--- include/diagUart_settings.svh
`ifndef DIAG_UART_SETTINGS_SVH
`define DIAG_UART_SETTINGS_SVH

// burst geometry
`define DIAG_BURST_BYTES 18   // bytes sent per request
`define DIAG_ADDR_W 9         // frame memory address width, 512 bytes

// line timing in core clocks
`define DIAG_CLKS_PER_BIT 4   // clocks per uart bit

// rs485 transceiver turnaround, in clocks
`define DIAG_DIR_TX_LEAD 15   // dirRx rise to dirTx rise
`define DIAG_DIR_SETTLE 30    // dirRx rise to ready
`define DIAG_DIR_RELEASE 4    // dirTx fall to dirRx fall

`endif

//--- hdl/diagUartPkg.sv
`include "diagUart_settings.svh"

package diagUartPkg;

  // host side write strobe into the frame memory
  typedef struct packed {
    logic                    en;    // write this clock
    logic [`DIAG_ADDR_W-1:0] addr;  // byte address
    logic [7:0]              data;  // byte to store
  } memWrite_t;

  // everything that goes out to the rs485 transceiver
  typedef struct packed {
    logic tx;     // uart line, idles high
    logic dirTx;  // driver enable
    logic dirRx;  // receiver side of the turnaround
  } lineOut_t;

  // one-cycle strobes from the sequencer to the direction controller
  // (release is a keyword, hence releaseBus)
  typedef struct packed {
    logic enable;      // start turn-on
    logic releaseBus;  // start turn-off
  } dirCmd_t;

  // burst sequencer states
  typedef enum logic [2:0] {
    idle     = 3'd0,  // waiting for rq
    turnOn   = 3'd1,  // transceiver settling
    fetch    = 3'd2,  // first read address out
    send     = 3'd3,  // load byte, wait for serializer
    turnOff  = 3'd4,  // bus release in progress
    holdDone = 3'd5   // done high until rq drops
  } burstState_t;

endpackage

//--- hdl/diagFrameMem.sv
`timescale 1ns/1ps
`include "diagUart_settings.svh"

module diagFrameMem
  import diagUartPkg::*;
(
  input  logic                    clk,
  input  memWrite_t               memWr,
  input  logic [`DIAG_ADDR_W-1:0] rdAddr,
  output logic [7:0]              rdData
);

  localparam int Depth = 2 ** `DIAG_ADDR_W;  // 512 bytes

  logic [7:0] mem [Depth];  // diagnostic image, contents undefined until written

  // host write port
  always_ff @(posedge clk) begin
    if (memWr.en) begin
      mem[memWr.addr] <= memWr.data;  // one byte per strobe
    end
  end

  // registered read, data one clock after address
  always_ff @(posedge clk) begin
    rdData <= mem[rdAddr];  // reads every clock, sequencer picks the cycle
  end

endmodule

//--- hdl/rs485DirCtrl.sv
`timescale 1ns/1ps
`include "diagUart_settings.svh"

module rs485DirCtrl
  import diagUartPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  dirCmd_t dirCmd,
  output logic    ready,
  output logic    released,
  output logic    dirTx,
  output logic    dirRx
);

  localparam int MaxDelay = (`DIAG_DIR_SETTLE > `DIAG_DIR_RELEASE) ?
                            `DIAG_DIR_SETTLE : `DIAG_DIR_RELEASE;
  localparam int CntW = $clog2(MaxDelay + 1);

  localparam logic [CntW-1:0] TxLeadHit  = CntW'(`DIAG_DIR_TX_LEAD - 1);  // dirTx rises next
  localparam logic [CntW-1:0] SettleHit  = CntW'(`DIAG_DIR_SETTLE - 1);   // ready rises next
  localparam logic [CntW-1:0] ReleaseHit = CntW'(`DIAG_DIR_RELEASE - 1);  // dirRx falls next

  logic [CntW-1:0] delayCnt;  // shared by turn-on and turn-off
  logic            turningOn;
  logic            turningOff;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      delayCnt   <= '0;
      turningOn  <= 1'b0;
      turningOff <= 1'b0;
      ready      <= 1'b0;
      released   <= 1'b0;
      dirTx      <= 1'b0;
      dirRx      <= 1'b0;
    end else begin
      released <= 1'b0;  // single-cycle pulse
      if (dirCmd.enable) begin
        dirRx     <= 1'b1;  // receiver side first
        turningOn <= 1'b1;
        delayCnt  <= '0;
      end else if (dirCmd.releaseBus) begin
        dirTx      <= 1'b0;  // driver off right away
        ready      <= 1'b0;
        turningOn  <= 1'b0;
        turningOff <= 1'b1;
        delayCnt   <= '0;
      end else if (turningOn) begin
        delayCnt <= delayCnt + 1'b1;
        if (delayCnt == TxLeadHit) begin
          dirTx <= 1'b1;  // driver on after the lead time
        end
        if (delayCnt == SettleHit) begin
          ready     <= 1'b1;  // line settled, sequencer may send
          turningOn <= 1'b0;
        end
      end else if (turningOff) begin
        delayCnt <= delayCnt + 1'b1;
        if (delayCnt == ReleaseHit) begin
          dirRx      <= 1'b0;  // bus handed back
          released   <= 1'b1;
          turningOff <= 1'b0;
        end
      end
    end
  end

  // driver never enabled without the receiver side already up
  dirTxNeedsRx: assert property (@(posedge clk) disable iff (!reset)
    dirTx |-> dirRx);

  // a new turn-on only after the previous burst gave the bus back
  noEnableWhileOn: assert property (@(posedge clk) disable iff (!reset)
    dirCmd.enable |-> !dirRx);

endmodule

//--- hdl/uartSerializer.sv
`timescale 1ns/1ps
`include "diagUart_settings.svh"

module uartSerializer (
  input  logic       clk,
  input  logic       reset,
  input  logic       load,
  input  logic [7:0] byteIn,
  output logic       busy,
  output logic       tx
);

  localparam int BitCntW = $clog2(`DIAG_CLKS_PER_BIT + 1);
  localparam logic [BitCntW-1:0] BitEnd = BitCntW'(`DIAG_CLKS_PER_BIT - 1);
  localparam logic [3:0] IdleIdx = 4'd10;  // start, 8 data, stop, then idle

  logic [BitCntW-1:0] bitCnt;    // clocks into the current bit
  logic [3:0]         bitIdx;    // 0 start, 1..8 data, 9 stop, 10 idle
  logic [7:0]         shiftReg;  // data bits, lsb goes out next

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      busy     <= 1'b0;
      tx       <= 1'b1;  // line idles high
      bitCnt   <= '0;
      bitIdx   <= '0;
      shiftReg <= '0;
    end else if (load) begin
      busy     <= 1'b1;
      tx       <= 1'b0;  // start bit on the next clock
      bitCnt   <= '0;
      bitIdx   <= '0;
      shiftReg <= byteIn;
    end else if (busy) begin
      if (bitCnt == BitEnd) begin
        bitCnt <= '0;
        bitIdx <= bitIdx + 1'b1;
        if (bitIdx == IdleIdx) begin
          busy <= 1'b0;  // idle bit time over
          tx   <= 1'b1;
        end else begin
          // ones shift in behind the data, so stop and idle come out high
          tx       <= shiftReg[0];
          shiftReg <= {1'b1, shiftReg[7:1]};
        end
      end else begin
        bitCnt <= bitCnt + 1'b1;  // hold the bit
      end
    end else begin
      tx <= 1'b1;  // not busy, keep line high
    end
  end

  // sequencer must wait for busy to drop before the next byte
  noLoadWhileBusy: assert property (@(posedge clk) disable iff (!reset)
    load |-> !busy);

endmodule

//--- hdl/diagTxSequencer.sv
`timescale 1ns/1ps
`include "diagUart_settings.svh"

module diagTxSequencer
  import diagUartPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    rq,
  input  logic [5:0]              bank,
  output logic [`DIAG_ADDR_W-1:0] rdAddr,
  input  logic [7:0]              rdData,
  output dirCmd_t                 dirCmd,
  input  logic                    ready,
  input  logic                    released,
  output logic                    load,
  output logic [7:0]              byteOut,
  input  logic                    busy,
  output logic                    done
);

  localparam int AddrW = `DIAG_ADDR_W;
  localparam int CntW  = $clog2(`DIAG_BURST_BYTES + 1);
  localparam logic [CntW-1:0] LastCnt = CntW'(`DIAG_BURST_BYTES);

  burstState_t     state;
  logic [1:0]      rqSync;   // two flops, rq is from another domain
  logic [CntW-1:0] byteCnt;  // bytes handed to the serializer so far
  logic            loaded;   // current byte already loaded

  // block base is four bytes per bank step
  assign rdAddr  = AddrW'(byteCnt) + AddrW'({bank, 2'b00});
  assign load    = (state == send) && !loaded;  // data is one clock behind the address
  assign byteOut = rdData;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      rqSync  <= '0;
      state   <= idle;
      byteCnt <= '0;
      loaded  <= 1'b0;
      dirCmd  <= '0;
      done    <= 1'b0;
    end else begin
      rqSync <= {rqSync[0], rq};
      dirCmd <= '0;  // strobes last one clock
      case (state)
        idle: begin
          done    <= 1'b0;
          byteCnt <= '0;
          loaded  <= 1'b0;
          if (rqSync[1]) begin
            dirCmd.enable <= 1'b1;  // turn transceiver around
            state         <= turnOn;
          end
        end
        turnOn: begin
          if (ready) begin
            state <= fetch;  // settle time elapsed
          end
        end
        fetch: begin
          state <= send;  // byte 0 address goes into the memory register
        end
        send: begin
          if (!loaded) begin
            loaded  <= 1'b1;
            byteCnt <= byteCnt + 1'b1;  // next address already out during the frame
          end else if (!busy) begin
            loaded <= 1'b0;  // next byte loads on the following clock
            if (byteCnt == LastCnt) begin
              dirCmd.releaseBus <= 1'b1;  // last frame and idle bit done
              state             <= turnOff;
            end
          end
        end
        turnOff: begin
          if (released) begin
            done  <= 1'b1;
            state <= holdDone;
          end
        end
        holdDone: begin
          if (!rqSync[1]) begin
            state <= idle;  // done clears there, one clock later
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // counter stops at the burst length
  byteCntInRange: assert property (@(posedge clk) disable iff (!reset)
    byteCnt <= LastCnt);

endmodule

//--- hdl/diagUartTop.sv
`timescale 1ns/1ps
`include "diagUart_settings.svh"

module diagUartTop
  import diagUartPkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  memWrite_t  memWr,
  input  logic       rq,
  input  logic [5:0] bank,
  output lineOut_t   line,
  output logic       done
);

  logic [`DIAG_ADDR_W-1:0] rdAddr;   // sequencer to memory
  logic [7:0]              rdData;   // memory to sequencer
  logic [7:0]              txByte;   // byte into the serializer
  dirCmd_t                 dirCmd;
  logic                    ready;     // transceiver settled
  logic                    released;  // bus handed back
  logic                    load;
  logic                    busy;
  logic                    tx;
  logic                    dirTx;
  logic                    dirRx;

  diagFrameMem frameMem (
    .clk    (clk),
    .memWr  (memWr),
    .rdAddr (rdAddr),
    .rdData (rdData)
  );

  diagTxSequencer sequencer (
    .clk      (clk),
    .reset    (reset),
    .rq       (rq),
    .bank     (bank),
    .rdAddr   (rdAddr),
    .rdData   (rdData),
    .dirCmd   (dirCmd),
    .ready    (ready),
    .released (released),
    .load     (load),
    .byteOut  (txByte),
    .busy     (busy),
    .done     (done)
  );

  rs485DirCtrl dirCtrl (
    .clk      (clk),
    .reset    (reset),
    .dirCmd   (dirCmd),
    .ready    (ready),
    .released (released),
    .dirTx    (dirTx),
    .dirRx    (dirRx)
  );

  uartSerializer serializer (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .byteIn (txByte),
    .busy   (busy),
    .tx     (tx)
  );

  assign line = '{tx: tx, dirTx: dirTx, dirRx: dirRx};  // pins out to the transceiver

endmodule

//--- test/diagUartChecker.sv
`timescale 1ns/1ps
`include "diagUart_settings.svh"

module diagUartChecker
  import diagUartPkg::*;
(
  input  logic                              clk,
  input  logic                              reset,
  input  lineOut_t                          line,
  input  logic                              done,
  input  logic                              rq,
  input  logic [`DIAG_BURST_BYTES-1:0][7:0] expBytes,   // expected bytes of the running burst
  input  logic [8*16-1:0]                   testName,
  output int                                errorCount
);

  localparam int Cpb       = `DIAG_CLKS_PER_BIT;
  localparam int FrameClks = 10 * Cpb;     // start, 8 data, stop
  localparam int StartGap  = 11 * Cpb + 2; // start to start, idle bit plus reload

  lineOut_t   prevLine;
  logic       prevDone;
  logic       prevRq;
  logic       inFrame;     // decoding a frame right now
  logic       allowBurst;  // rq rose since the last turn-on
  logic       bitLevel;    // first sample of the current bit
  logic       bitSteady;   // bit held its level so far
  logic [9:0] frameBits;   // mid-bit samples
  int         pos;         // clocks into the frame
  int         frameCnt;    // frames seen in this burst
  int         sinceStart;
  int         sinceRxRise;
  int         sinceTxFall;
  int         sinceRxFall;

  initial errorCount = 0;

  task automatic reportMismatch(input string what, input int expVal, input int actVal);
    errorCount++;
    $display("CHECK FAILED %0s: %0s expected %0d actual %0d", testName, what, expVal, actVal);
  endtask

  task automatic reportProblem(input string what);
    errorCount++;
    $display("%0s: %0s", testName, what);
  endtask

  // everything sampled on the falling edge, away from dut updates
  always @(negedge clk) begin
    if (!reset) begin
      prevLine    = line;
      prevDone    = done;
      prevRq      = rq;
      inFrame     = 1'b0;
      allowBurst  = 1'b0;
      frameCnt    = 0;
      pos         = 0;
      sinceStart  = 0;
      sinceRxRise = 0;
      sinceTxFall = 0;
      sinceRxFall = 0;
    end else begin
      sinceRxRise++;
      sinceTxFall++;
      sinceRxFall++;
      sinceStart++;
      if (rq && !prevRq) allowBurst = 1'b1;  // new request seen
      if (line.dirRx && !prevLine.dirRx) begin
        if (!allowBurst) reportProblem("transceiver turned on without a new request");
        allowBurst  = 1'b0;
        sinceRxRise = 0;
        frameCnt    = 0;  // burst starts
      end
      if (line.dirTx && !prevLine.dirTx) begin
        if (sinceRxRise != `DIAG_DIR_TX_LEAD)
          reportMismatch("dirTx lead after dirRx", `DIAG_DIR_TX_LEAD, sinceRxRise);
      end
      if (!line.dirTx && prevLine.dirTx) sinceTxFall = 0;
      if (!line.dirRx && prevLine.dirRx) begin
        if (sinceTxFall != `DIAG_DIR_RELEASE)
          reportMismatch("dirRx release after dirTx", `DIAG_DIR_RELEASE, sinceTxFall);
        if (frameCnt != `DIAG_BURST_BYTES)
          reportMismatch("frames per burst", `DIAG_BURST_BYTES, frameCnt);
        sinceRxFall = 0;  // burst over
      end
      if (done && !prevDone && sinceRxFall != 1)
        reportMismatch("done rise after dirRx fall", 1, sinceRxFall);
      if (!done && prevDone && rq) reportProblem("done dropped while rq was still high");
      if (!line.tx && !line.dirTx) reportProblem("tx was low while the driver was off");

      // frame decoder
      if (!inFrame && !line.tx) begin
        if (frameCnt > 0 && sinceStart != StartGap)
          reportMismatch("clocks between start bits", StartGap, sinceStart);
        inFrame    = 1'b1;
        pos        = 0;
        sinceStart = 0;
      end
      if (inFrame) begin
        if (pos % Cpb == 0) begin
          bitLevel  = line.tx;  // bit begins
          bitSteady = 1'b1;
        end else if (line.tx != bitLevel) begin
          bitSteady = 1'b0;
        end
        if (pos % Cpb == Cpb / 2) frameBits[pos / Cpb] = line.tx;  // mid-bit sample
        if (pos % Cpb == Cpb - 1 && !bitSteady)
          reportProblem($sformatf("bit %0d of frame %0d changed within its bit time",
                                  pos / Cpb, frameCnt));
        if (pos == FrameClks - 1) begin
          inFrame = 1'b0;
          if (frameBits[0] !== 1'b0) reportMismatch("start bit level", 0, frameBits[0]);
          if (frameBits[9] !== 1'b1) reportMismatch("stop bit level", 1, frameBits[9]);
          if (frameCnt >= `DIAG_BURST_BYTES) begin
            reportProblem("more frames than the burst length");
          end else if (frameBits[8:1] !== expBytes[frameCnt]) begin
            errorCount++;
            $display("CHECK FAILED %0s: frame %0d byte expected %h actual %h",
                     testName, frameCnt, expBytes[frameCnt], frameBits[8:1]);
          end
          frameCnt++;
        end
        pos++;
      end
      prevLine = line;
      prevDone = done;
      prevRq   = rq;
    end
  end

endmodule

//--- test/diagUartTb.sv
`timescale 1ns/1ps
`include "diagUart_settings.svh"

module diagUartTb
  import diagUartPkg::*;
();

  localparam int Depth      = 2 ** `DIAG_ADDR_W;
  localparam int BurstLimit = 2 * (`DIAG_DIR_SETTLE +
                              `DIAG_BURST_BYTES * (11 * `DIAG_CLKS_PER_BIT + 2)) + 100;

  logic       clk;
  logic       reset;
  memWrite_t  memWr;
  logic       rq;
  logic [5:0] bank;
  lineOut_t   line;
  logic       done;

  logic [7:0]                        image [Depth];  // copy of what the host wrote
  logic [`DIAG_BURST_BYTES-1:0][7:0] expBytes;
  logic [8*16-1:0]                   testName;
  integer                            seed = 47;
  int                                tbErrors;
  int                                checkErrors;

  diagUartTop uut (
    .clk   (clk),
    .reset (reset),
    .memWr (memWr),
    .rq    (rq),
    .bank  (bank),
    .line  (line),
    .done  (done)
  );

  diagUartChecker lineChecker (
    .clk        (clk),
    .reset      (reset),
    .line       (line),
    .done       (done),
    .rq         (rq),
    .expBytes   (expBytes),
    .testName   (testName),
    .errorCount (checkErrors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 100 MHz
  end

  // byte k of a burst comes from k plus four times bank
  function automatic logic [7:0] expectedByte(input logic [5:0] bankVal, input int index);
    return image[index + 4 * bankVal];
  endfunction

  task automatic checkLevel(input string what, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      tbErrors++;
      $display("CHECK FAILED idle after reset: %0s expected %0b actual %0b",
               what, expVal, actVal);
    end
  endtask

  task automatic waitForDone(input logic level, input int limit, input logic [8*16-1:0] what);
    int count;
    count = 0;
    do begin
      @(negedge clk);
      count++;
    end while (done !== level && count < limit);
    if (done !== level) begin
      tbErrors++;
      $display("timeout: done did not go to %0b within %0d clocks during %0s",
               level, limit, what);
    end
  endtask

  task automatic fillMemory();
    logic [7:0] byteVal;
    for (int a = 0; a < Depth; a++) begin
      byteVal = $random(seed);
      @(posedge clk);
      memWr <= '{en: 1'b1, addr: a[`DIAG_ADDR_W-1:0], data: byteVal};
      image[a] = byteVal;  // reference image
    end
    @(posedge clk);
    memWr <= '0;
  endtask

  task automatic runBurst(input logic [5:0] bankVal, input logic [8*16-1:0] name);
    @(posedge clk);
    for (int k = 0; k < `DIAG_BURST_BYTES; k++) begin
      expBytes[k] = expectedByte(bankVal, k);
    end
    testName <= name;
    bank     <= bankVal;
    rq       <= 1'b1;
    waitForDone(1'b1, BurstLimit, name);
    repeat (20) @(posedge clk);  // rq held, done has to stay up
    rq <= 1'b0;
    waitForDone(1'b0, 10, name);
    repeat (40) @(posedge clk);  // quiet gap, no new burst allowed
  endtask

  initial begin
    logic [5:0] bankVal;
    reset    = 1'b0;
    memWr    = '0;
    rq       = 1'b0;
    bank     = '0;
    expBytes = '0;
    testName = "reset";
    tbErrors = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b1;
    @(negedge clk);
    checkLevel("tx", 1'b1, line.tx);
    checkLevel("dirTx", 1'b0, line.dirTx);
    checkLevel("dirRx", 1'b0, line.dirRx);
    checkLevel("done", 1'b0, done);
    fillMemory();
    runBurst(6'd0, "burst content");
    for (int i = 0; i < 3; i++) begin
      bankVal = $random(seed);
      runBurst(bankVal, "bank offset");
    end
    repeat (5) @(posedge clk);
    $display("errors: checker %0d, testbench %0d", checkErrors, tbErrors);
    if (checkErrors == 0 && tbErrors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- diagUartTop.f
+incdir+include
hdl/diagUartPkg.sv
hdl/diagFrameMem.sv
hdl/rs485DirCtrl.sv
hdl/uartSerializer.sv
hdl/diagTxSequencer.sv
hdl/diagUartTop.sv
test/diagUartChecker.sv
test/diagUartTb.sv

//--- Bender.yml
package:
  name: diagUart

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/diagUartPkg.sv
      - hdl/diagFrameMem.sv
      - hdl/rs485DirCtrl.sv
      - hdl/uartSerializer.sv
      - hdl/diagTxSequencer.sv
      - hdl/diagUartTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/diagUartChecker.sv
      - test/diagUartTb.sv
